/* include/mister_cfg.svh */
// Widths, HPS file indices and status word bit positions
// shared by the shell, its package and its blocks

`ifndef MISTER_CFG_SVH
`define MISTER_CFG_SVH

// Bus widths
`define MR_STATUS_W      64
`define MR_ADDR_W        27
`define MR_DDR_ADDR_W    29
`define MR_DDR_BCNT_W    8

// File indices on the HPS stream
`define MR_IDX_ROM       0
`define MR_IDX_MOD       1
`define MR_IDX_CHEAT     16
`define MR_IDX_DIP       254

// Status word fields
`define MR_ST_HSIZE_EN   19
// Four bits, horizontal scale factor
`define MR_ST_HSCALE_LO  20
// Four bits each, CRT position offsets
`define MR_ST_HOFS_LO    24
`define MR_ST_VOFS_LO    28
// Three bits of mask type, then the 2x flag
`define MR_ST_SHMASK_LO  32
`define MR_ST_SHMASK_2X  35
`define MR_ST_DB15       36

// Sync delay line depth
`define MR_OFS_TAPS      16

`endif

/* hdl/mister_pkg.sv */
// Data types shared across the shell blocks

`default_nettype none

`include "mister_cfg.svh"

package mister_pkg;

    // HPS stream
    typedef logic [7:0]                  byte_t;
    typedef logic [`MR_ADDR_W-1:0]       hps_addr_t;

    // Settings
    typedef logic [`MR_STATUS_W-1:0]     status_t;
    typedef logic [3:0]                  offset_t;
    typedef logic [31:0]                 word32_t;

    // DDR port
    typedef logic [`MR_DDR_ADDR_W-1:0]   ddr_addr_t;
    typedef logic [`MR_DDR_BCNT_W-1:0]   burst_t;

endpackage

`default_nettype wire

/* hdl/hps_dwnld.sv */
// HPS write stream router
// ROM bytes go to the programming port under a wait handshake,
// setting bytes go into the core mode, cheat and DIP registers

`default_nettype none
`timescale 1ns/1ps

`include "mister_cfg.svh"

module hps_dwnld (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  logic                    hps_download,
    input  logic                    hps_wr,
    input  mister_pkg::byte_t       hps_index,
    input  mister_pkg::hps_addr_t   hps_addr,
    input  mister_pkg::byte_t       hps_dout,
    input  logic                    prog_rdy,
    output logic                    hps_wait,
    output logic                    ioctl_rom_wr,
    output mister_pkg::hps_addr_t   ioctl_addr,
    output mister_pkg::byte_t       ioctl_dout,
    output logic                    downloading,
    output mister_pkg::byte_t       core_mod,
    output mister_pkg::word32_t     cheat,
    output mister_pkg::word32_t     dipsw
);

    import mister_pkg::*;

    logic take;
    logic is_rom;
    logic is_mod;
    logic is_cheat;
    logic is_dip;

    // Replace one byte lane of a 32-bit settings word
    function automatic word32_t put_byte(
        input word32_t    w,
        input logic [1:0] lane,
        input byte_t      b
    );
        word32_t r;
        r = w;
        r[{lane, 3'b000} +: 8] = b;
        return r;
    endfunction

    // Source holds hps_wr low while we stall it
    assign take     = hps_wr & ~hps_wait;

    assign is_rom   = hps_index == byte_t'(`MR_IDX_ROM);
    assign is_mod   = hps_index == byte_t'(`MR_IDX_MOD);
    assign is_cheat = hps_index == byte_t'(`MR_IDX_CHEAT);
    assign is_dip   = hps_index == byte_t'(`MR_IDX_DIP);

    // ROM handshake
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            ioctl_rom_wr <= 1'b0;
            hps_wait     <= 1'b0;
            downloading  <= 1'b0;
        end else begin
            ioctl_rom_wr <= take & is_rom;
            downloading  <= hps_download & is_rom;
            if (take && is_rom) begin
                hps_wait <= 1'b1;
            end else if (prog_rdy) begin
                // Loader has consumed the byte
                hps_wait <= 1'b0;
            end
        end
    end

    // ROM payload, valid with the write pulse
    always_ff @(posedge clk_sys) begin
        if (take && is_rom) begin
            ioctl_addr <= hps_addr;
            ioctl_dout <= hps_dout;
        end
    end

    // Settings words, written byte by byte
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            core_mod <= '0;
            cheat    <= '0;
            dipsw    <= '0;
        end else if (take) begin
            // Core mode is a single byte at offset 0
            if (is_mod && hps_addr[1:0] == 2'd0) begin
                core_mod <= hps_dout;
            end
            if (is_cheat) begin
                cheat <= put_byte(cheat, hps_addr[1:0], hps_dout);
            end
            if (is_dip) begin
                dipsw <= put_byte(dipsw, hps_addr[1:0], hps_dout);
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/status_decode.sv */
// OSD status word decoder
// Registers CRT offsets, scaling, shadow mask and DB15 fields,
// and builds the mask that hides unused menu items

`default_nettype none
`timescale 1ns/1ps

`include "mister_cfg.svh"

module status_decode (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  mister_pkg::status_t     status,
    input  logic                    vertical,
    input  logic                    rotate,
    output mister_pkg::offset_t     hoffset,
    output mister_pkg::offset_t     voffset,
    output logic                    hsize_enable,
    output mister_pkg::offset_t     hsize_scale,
    output logic [2:0]              shadowmask,
    output logic                    shadowmask_2x,
    output logic                    shadowmask_rot,
    output logic                    db15_en,
    output logic [15:0]             status_menumask
);

    logic [2:0] shmask_in;
    logic       hsize_in;

    assign shmask_in = status[`MR_ST_SHMASK_LO +: 3];
    assign hsize_in  = status[`MR_ST_HSIZE_EN];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hoffset         <= '0;
            voffset         <= '0;
            hsize_enable    <= 1'b0;
            hsize_scale     <= '0;
            shadowmask      <= '0;
            shadowmask_2x   <= 1'b0;
            shadowmask_rot  <= 1'b0;
            db15_en         <= 1'b0;
            status_menumask <= '0;
        end else begin
            hoffset         <= status[`MR_ST_HOFS_LO +: 4];
            voffset         <= status[`MR_ST_VOFS_LO +: 4];
            hsize_enable    <= hsize_in;
            hsize_scale     <= status[`MR_ST_HSCALE_LO +: 4];
            shadowmask      <= shmask_in;
            shadowmask_2x   <= status[`MR_ST_SHMASK_2X];
            // Mask turns with the screen only on vertical games
            shadowmask_rot  <= vertical & rotate;
            db15_en         <= status[`MR_ST_DB15];
            // High bit hides the item, bit 0 was direct video
            status_menumask <= {12'd0, shmask_in == 3'd0, ~hsize_in, ~vertical, 1'b0};
        end
    end

endmodule

`default_nettype wire

/* hdl/video_resync.sv */
// CRT position adjust
// Delays hs by a number of pixels and vs by a number of lines,
// each through a tap line with a selectable output tap

`default_nettype none
`timescale 1ns/1ps

`include "mister_cfg.svh"

module video_resync (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    hs,
    input  logic                    vs,
    input  mister_pkg::offset_t     hoffset,
    input  mister_pkg::offset_t     voffset,
    output logic                    hs_out,
    output logic                    vs_out
);

    logic [`MR_OFS_TAPS-1:0] hs_line;
    logic [`MR_OFS_TAPS-1:0] vs_line;
    logic                    hs_prev;
    logic                    line_start;

    // Tap 0 holds the newest sample
    assign hs_out = hs_line[hoffset];
    assign vs_out = vs_line[voffset];

    // Rising edge of the delayed hs, seen on a pixel enable
    assign line_start = pxl_cen & hs_out & ~hs_prev;

    // Pixel delay
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hs_line <= '0;
            hs_prev <= 1'b0;
        end else if (pxl_cen) begin
            hs_line <= {hs_line[`MR_OFS_TAPS-2:0], hs};
            hs_prev <= hs_out;
        end
    end

    // Line delay
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vs_line <= '0;
        end else if (line_start) begin
            vs_line <= {vs_line[`MR_OFS_TAPS-2:0], vs};
        end
    end

endmodule

`default_nettype wire

/* hdl/ddr_arbiter.sv */
// DDR port sharing between the fast loader and the screen rotator
// The loader owns the port while a ROM download runs

`default_nettype none
`timescale 1ns/1ps

module ddr_arbiter (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  logic                    downloading,
    // Loader, read only
    input  logic                    ddrld_rd,
    input  mister_pkg::ddr_addr_t   ddrld_addr,
    input  mister_pkg::burst_t      ddrld_burstcnt,
    output logic                    ddrld_busy,
    // Rotator
    input  logic                    rot_rd,
    input  logic                    rot_we,
    input  mister_pkg::ddr_addr_t   rot_addr,
    input  mister_pkg::burst_t      rot_burstcnt,
    input  logic [7:0]              rot_be,
    output logic                    rot_busy,
    // Memory side
    input  logic                    ddr_busy,
    output logic                    ddr_rd,
    output logic                    ddr_we,
    output mister_pkg::ddr_addr_t   ddr_addr,
    output mister_pkg::burst_t      ddr_burstcnt,
    output logic [7:0]              ddr_be
);

    logic ld_sel;

    // Rotator owns the port out of reset
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            ld_sel <= 1'b0;
        end else begin
            ld_sel <= downloading;
        end
    end

    assign ddr_rd       = ld_sel ? ddrld_rd       : rot_rd;
    assign ddr_we       = ld_sel ? 1'b0           : rot_we;
    assign ddr_addr     = ld_sel ? ddrld_addr     : rot_addr;
    assign ddr_burstcnt = ld_sel ? ddrld_burstcnt : rot_burstcnt;
    assign ddr_be       = ld_sel ? 8'hff          : rot_be;

    // Requester without the port is held off
    assign ddrld_busy   = ld_sel ? ddr_busy : 1'b1;
    assign rot_busy     = ld_sel ? 1'b1     : ddr_busy;

endmodule

`default_nettype wire

/* hdl/mister_shell.sv */
// Shell top level between the platform service bus and the game
// Connects the download router, status decoder, sync delay and DDR arbiter

`default_nettype none
`timescale 1ns/1ps

module mister_shell (
    input  logic                    clk_sys,
    input  logic                    rst,
    // HPS file stream
    input  logic                    hps_download,
    input  logic                    hps_wr,
    input  mister_pkg::byte_t       hps_index,
    input  mister_pkg::hps_addr_t   hps_addr,
    input  mister_pkg::byte_t       hps_dout,
    output logic                    hps_wait,
    // ROM programming and settings registers
    input  logic                    prog_rdy,
    output logic                    ioctl_rom_wr,
    output mister_pkg::hps_addr_t   ioctl_addr,
    output mister_pkg::byte_t       ioctl_dout,
    output logic                    downloading,
    output mister_pkg::byte_t       core_mod,
    output mister_pkg::word32_t     cheat,
    output mister_pkg::word32_t     dipsw,
    // OSD status
    input  mister_pkg::status_t     status,
    input  logic                    rotate,
    output logic                    hsize_enable,
    output mister_pkg::offset_t     hsize_scale,
    output logic [2:0]              shadowmask,
    output logic                    shadowmask_2x,
    output logic                    shadowmask_rot,
    output logic                    db15_en,
    output logic [15:0]             status_menumask,
    // Game video sync
    input  logic                    hs,
    input  logic                    vs,
    input  logic                    pxl_cen,
    output logic                    hs_out,
    output logic                    vs_out,
    // Fast loader requests
    input  logic                    ddrld_rd,
    input  mister_pkg::ddr_addr_t   ddrld_addr,
    input  mister_pkg::burst_t      ddrld_burstcnt,
    output logic                    ddrld_busy,
    // Screen rotator requests
    input  logic                    rot_rd,
    input  logic                    rot_we,
    input  mister_pkg::ddr_addr_t   rot_addr,
    input  mister_pkg::burst_t      rot_burstcnt,
    input  logic [7:0]              rot_be,
    output logic                    rot_busy,
    // Shared DDR port
    output logic                    ddr_rd,
    output logic                    ddr_we,
    output mister_pkg::ddr_addr_t   ddr_addr,
    output mister_pkg::burst_t      ddr_burstcnt,
    output logic [7:0]              ddr_be,
    input  logic                    ddr_busy
);

    import mister_pkg::*;

    // CRT position from the OSD
    offset_t hoffset;
    offset_t voffset;

    // Port names match the top level throughout
    hps_dwnld u_dwnld (.*);

    // Bit 0 of the core mode marks a vertical game
    status_decode u_status (
        .vertical   ( core_mod[0] ),
        .*
    );

    video_resync u_resync (.*);

    ddr_arbiter u_ddrmux (.*);

endmodule

`default_nettype wire

/* bench/shell_checker.sv */
// Watches the shell outputs and compares them with expected values
// Prints a line per finished test and the closing counts

`default_nettype none
`timescale 1ns/1ps

module shell_checker (
    input  logic                    ioctl_rom_wr,
    input  mister_pkg::hps_addr_t   ioctl_addr,
    input  mister_pkg::byte_t       ioctl_dout,
    input  logic                    hps_wait,
    input  logic                    downloading,
    input  mister_pkg::word32_t     cheat,
    input  mister_pkg::word32_t     dipsw,
    input  mister_pkg::byte_t       core_mod,
    input  logic                    hsize_enable,
    input  mister_pkg::offset_t     hsize_scale,
    input  logic [2:0]              shadowmask,
    input  logic                    shadowmask_2x,
    input  logic                    shadowmask_rot,
    input  logic                    db15_en,
    input  logic [15:0]             status_menumask,
    input  logic                    hs_out,
    input  logic                    vs_out,
    input  logic                    ddr_rd,
    input  logic                    ddr_we,
    input  mister_pkg::ddr_addr_t   ddr_addr,
    input  mister_pkg::burst_t      ddr_burstcnt,
    input  logic [7:0]              ddr_be,
    input  logic                    ddrld_busy,
    input  logic                    rot_busy,
    output int                      err_count
);

    int test_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;

    string names [24] = '{"ioctl_rom_wr", "ioctl_addr", "ioctl_dout", "hps_wait",
        "downloading", "cheat", "dipsw", "core_mod", "hsize_enable", "hsize_scale",
        "shadowmask", "shadowmask_2x", "shadowmask_rot", "db15_en", "status_menumask",
        "hs_out", "vs_out", "ddr_rd", "ddr_we", "ddr_addr", "ddr_burstcnt", "ddr_be",
        "ddrld_busy", "rot_busy"};

    initial err_count = 0;

    // Current value of a watched output, by code
    function automatic logic [63:0] pick(input int code);
        case (code)
            0:  return 64'(ioctl_rom_wr);
            1:  return 64'(ioctl_addr);
            2:  return 64'(ioctl_dout);
            3:  return 64'(hps_wait);
            4:  return 64'(downloading);
            5:  return 64'(cheat);
            6:  return 64'(dipsw);
            7:  return 64'(core_mod);
            8:  return 64'(hsize_enable);
            9:  return 64'(hsize_scale);
            10: return 64'(shadowmask);
            11: return 64'(shadowmask_2x);
            12: return 64'(shadowmask_rot);
            13: return 64'(db15_en);
            14: return 64'(status_menumask);
            15: return 64'(hs_out);
            16: return 64'(vs_out);
            17: return 64'(ddr_rd);
            18: return 64'(ddr_we);
            19: return 64'(ddr_addr);
            20: return 64'(ddr_burstcnt);
            21: return 64'(ddr_be);
            22: return 64'(ddrld_busy);
            default: return 64'(rot_busy);
        endcase
    endfunction

    task automatic expect_sig(input int code, input logic [63:0] exp);
        logic [63:0] got;
        got = pick(code);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s expected %0h got %0h", $time, names[code], exp, got);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic report_stall(input string what);
        $display("Stalled at %0t ns: %s", $time, what);
        err_count++;
        test_errs++;
    endtask

    task automatic finish_test(input int n, input string kind);
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %0d (%s) passed", n, kind);
        end else begin
            $display("Test %0d (%s) failed with %0d errors", n, kind, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic print_counts;
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    endtask

endmodule

`default_nettype wire

/* bench/shell_props.sv */
// Concurrent assertions on the ROM write handshake and the DDR select
// Bound into the download router and the DDR arbiter

`default_nettype none
`timescale 1ns/1ps

module shell_props (
    input logic clk_sys,
    input logic rst,
    input logic rom_wr,
    input logic wait_hi,
    input logic ddr_we,
    input logic ld_sel
);

    // A new ROM byte only when the previous one was released
    assert property (@(posedge clk_sys) disable iff (rst) rom_wr |-> !$past(wait_hi))
        else $error("ROM write pulse while hps_wait was high");

    assert property (@(posedge clk_sys) disable iff (rst) rom_wr |=> !rom_wr)
        else $error("ROM write pulse longer than one cycle");

    // Loader port is read only
    assert property (@(posedge clk_sys) disable iff (rst) ld_sel |-> !ddr_we)
        else $error("DDR write while the loader owns the port");

endmodule

bind hps_dwnld shell_props u_props_dl (
    .clk_sys (clk_sys),
    .rst     (rst),
    .rom_wr  (ioctl_rom_wr),
    .wait_hi (hps_wait),
    .ddr_we  (1'b0),
    .ld_sel  (1'b0)
);

bind ddr_arbiter shell_props u_props_ddr (
    .clk_sys (clk_sys),
    .rst     (rst),
    .rom_wr  (1'b0),
    .wait_hi (1'b0),
    .ddr_we  (ddr_we),
    .ld_sel  (ld_sel)
);

`default_nettype wire

/* bench/tb_mister_shell.sv */
// Testbench for the shell top level
// Clock, reset, stimulus table walked in a loop, watchdog, DUT and checker

`default_nettype none
`timescale 1ns/1ps

`include "mister_cfg.svh"

module tb_mister_shell;

    import mister_pkg::*;

    localparam int N_TESTS = 21;
    localparam int K_ROM = 0, K_SET = 1, K_CHK = 2, K_STATUS = 3, K_VIDEO = 4, K_DDR = 5;

    // Checker signal codes
    localparam int S_ROM_WR = 0, S_IO_ADDR = 1, S_IO_DOUT = 2, S_WAIT = 3, S_DOWNL = 4;
    localparam int S_CHEAT = 5, S_DIPSW = 6, S_CORE = 7, S_HSZ_EN = 8, S_HSZ_SC = 9;
    localparam int S_SHM = 10, S_SHM_2X = 11, S_SHM_ROT = 12, S_DB15 = 13, S_MENU = 14;
    localparam int S_HS = 15, S_VS = 16, S_DDR_RD = 17, S_DDR_WE = 18, S_DDR_ADDR = 19;
    localparam int S_DDR_BC = 20, S_DDR_BE = 21, S_LD_BUSY = 22, S_ROT_BUSY = 23;

    logic clk_sys, rst;
    logic hps_download, hps_wr, hps_wait, prog_rdy;
    byte_t hps_index, hps_dout, ioctl_dout, core_mod;
    hps_addr_t hps_addr, ioctl_addr;
    logic ioctl_rom_wr, downloading;
    word32_t cheat, dipsw;
    status_t status;
    logic rotate, hsize_enable, shadowmask_2x, shadowmask_rot, db15_en;
    offset_t hsize_scale;
    logic [2:0] shadowmask;
    logic [15:0] status_menumask;
    logic hs, vs, pxl_cen, hs_out, vs_out;
    logic ddrld_rd, ddrld_busy, rot_rd, rot_we, rot_busy, ddr_rd, ddr_we, ddr_busy;
    ddr_addr_t ddrld_addr, rot_addr, ddr_addr;
    burst_t ddrld_burstcnt, rot_burstcnt, ddr_burstcnt;
    logic [7:0] rot_be, ddr_be;
    int err_count;

    // Stimulus table
    int          kind [N_TESTS];
    logic [63:0] op_a [N_TESTS];
    logic [31:0] op_b [N_TESTS];
    logic [31:0] op_c [N_TESTS];
    string       kind_name [6] = '{"ROM write", "setting write", "settings check",
                                   "status", "resync", "DDR arbitration"};

    logic [31:0] rng;
    byte_t       core_seen;

    mister_shell dut (.*);

    shell_checker chk (.*);

    always #5 clk_sys = ~clk_sys;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic set_entry(input int i, input int k, input logic [63:0] a,
                             input logic [31:0] b, input logic [31:0] c);
        kind[i] = k;
        op_a[i] = a;
        op_b[i] = b;
        op_c[i] = c;
    endtask

    task automatic load_table;
        set_entry(0, K_ROM, 64'h0000100, 0, 0);
        set_entry(1, K_ROM, 64'h0000101, 0, 0);
        set_entry(2, K_ROM, 64'h1abcdef, 0, 0);
        // Cheat word bytes, then DIP bytes, then core mode
        set_entry(3, K_SET, `MR_IDX_CHEAT, 0, 32'h78);
        set_entry(4, K_SET, `MR_IDX_CHEAT, 1, 32'h56);
        set_entry(5, K_SET, `MR_IDX_CHEAT, 2, 32'h34);
        set_entry(6, K_SET, `MR_IDX_CHEAT, 3, 32'h12);
        set_entry(7, K_SET, `MR_IDX_DIP, 0, 32'hef);
        set_entry(8, K_SET, `MR_IDX_DIP, 1, 32'hbe);
        set_entry(9, K_SET, `MR_IDX_DIP, 2, 32'had);
        set_entry(10, K_SET, `MR_IDX_DIP, 3, 32'hde);
        set_entry(11, K_SET, `MR_IDX_MOD, 0, 32'h01);
        set_entry(12, K_CHK, 64'h12345678, 32'hdeadbeef, 32'h01);
        // Unknown index must leave every register alone
        set_entry(13, K_SET, 7, 0, 32'hff);
        set_entry(14, K_CHK, 64'h12345678, 32'hdeadbeef, 32'h01);
        set_entry(15, K_STATUS, 64'h0000_001d_00a8_0000, 1, 0);
        set_entry(16, K_STATUS, 64'h0, 0, 0);
        set_entry(17, K_VIDEO, 0, 0, 0);
        set_entry(18, K_VIDEO, 3, 5, 0);
        set_entry(19, K_VIDEO, 15, 15, 0);
        set_entry(20, K_DDR, 0, 0, 0);
    endtask

    task automatic rom_write(input hps_addr_t a);
        byte_t d;
        int delay;
        int n;
        rng = xorshift(rng);
        d = rng[7:0];
        delay = int'(rng[10:8]);
        hps_download = 1'b1;
        hps_index = `MR_IDX_ROM;
        hps_addr = a;
        hps_dout = d;
        hps_wr = 1'b1;
        @(negedge clk_sys);
        chk.expect_sig(S_ROM_WR, 1);
        chk.expect_sig(S_IO_ADDR, 64'(a));
        chk.expect_sig(S_IO_DOUT, 64'(d));
        chk.expect_sig(S_WAIT, 1);
        chk.expect_sig(S_DOWNL, 1);
        hps_wr = 1'b0;
        // Wait holds while the loader is busy
        for (int i = 0; i < delay; i++) begin
            @(negedge clk_sys);
            chk.expect_sig(S_WAIT, 1);
            chk.expect_sig(S_ROM_WR, 0);
        end
        prog_rdy = 1'b1;
        @(negedge clk_sys);
        prog_rdy = 1'b0;
        chk.expect_sig(S_WAIT, 0);
        n = 0;
        while (hps_wait && n < 20) begin
            @(negedge clk_sys);
            n++;
        end
        if (hps_wait) begin
            chk.report_stall("hps_wait never fell after prog_rdy");
        end
    endtask

    task automatic set_write(input byte_t idx, input hps_addr_t a, input byte_t d);
        hps_download = 1'b0;
        hps_index = idx;
        hps_addr = a;
        hps_dout = d;
        hps_wr = 1'b1;
        @(negedge clk_sys);
        hps_wr = 1'b0;
        @(negedge clk_sys);
    endtask

    task automatic status_check(input status_t s, input logic rot);
        logic vert;
        logic [15:0] menu;
        vert = core_seen[0];
        menu = {12'd0, s[34:32] == 3'd0, ~s[19], ~vert, 1'b0};
        status = s;
        rotate = rot;
        @(negedge clk_sys);
        chk.expect_sig(S_HSZ_EN, 64'(s[19]));
        chk.expect_sig(S_HSZ_SC, 64'(s[23:20]));
        chk.expect_sig(S_SHM, 64'(s[34:32]));
        chk.expect_sig(S_SHM_2X, 64'(s[35]));
        chk.expect_sig(S_DB15, 64'(s[36]));
        chk.expect_sig(S_SHM_ROT, 64'(vert & rot));
        chk.expect_sig(S_MENU, 64'(menu));
    endtask

    task automatic resync_check(input int hoff, input int voff);
        logic [15:0] hq;
        logic [15:0] vq;
        logic hprev;
        int line;
        int e;
        logic en;
        hq = '0;
        vq = '0;
        hprev = 1'b0;
        status = '0;
        status[27:24] = 4'(hoff);
        status[31:28] = 4'(voff);
        @(negedge clk_sys);
        // 20 lines to flush both delay lines, then 20 checked lines
        for (int cyc = 0; cyc < 640; cyc++) begin
            line = cyc / 16;
            e = (cyc % 16) / 2;
            en = (cyc % 2) == 0;
            if (line >= 20) begin
                chk.expect_sig(S_HS, 64'(hq[hoff]));
                chk.expect_sig(S_VS, 64'(vq[voff]));
            end
            pxl_cen = en;
            hs = e < 2;
            vs = (line >= 20) && (line % 6) < 2;
            if (en) begin
                if (hq[hoff] && !hprev) begin
                    vq = {vq[14:0], vs};
                end
                hprev = hq[hoff];
                hq = {hq[14:0], hs};
            end
            @(negedge clk_sys);
        end
        pxl_cen = 1'b0;
    endtask

    task automatic ddr_check;
        hps_download = 1'b0;
        repeat (2) @(negedge clk_sys);
        // Rotator writes while the loader reads
        rot_rd = 1'b0;
        rot_we = 1'b1;
        rot_addr = 29'h0abc_123;
        rot_burstcnt = 8'd4;
        rot_be = 8'h0f;
        ddrld_rd = 1'b1;
        ddrld_addr = 29'h1555_0000;
        ddrld_burstcnt = 8'd16;
        ddr_busy = 1'b0;
        @(negedge clk_sys);
        chk.expect_sig(S_DDR_RD, 0);
        chk.expect_sig(S_DDR_WE, 1);
        chk.expect_sig(S_DDR_ADDR, 64'h0abc_123);
        chk.expect_sig(S_DDR_BC, 4);
        chk.expect_sig(S_DDR_BE, 8'h0f);
        chk.expect_sig(S_LD_BUSY, 1);
        chk.expect_sig(S_ROT_BUSY, 0);
        ddr_busy = 1'b1;
        @(negedge clk_sys);
        chk.expect_sig(S_LD_BUSY, 1);
        chk.expect_sig(S_ROT_BUSY, 1);
        ddr_busy = 1'b0;
        hps_download = 1'b1;
        hps_index = `MR_IDX_ROM;
        repeat (2) @(negedge clk_sys);
        chk.expect_sig(S_DDR_RD, 1);
        chk.expect_sig(S_DDR_WE, 0);
        chk.expect_sig(S_DDR_ADDR, 64'h1555_0000);
        chk.expect_sig(S_DDR_BC, 16);
        chk.expect_sig(S_DDR_BE, 8'hff);
        chk.expect_sig(S_LD_BUSY, 0);
        chk.expect_sig(S_ROT_BUSY, 1);
        ddr_busy = 1'b1;
        @(negedge clk_sys);
        chk.expect_sig(S_LD_BUSY, 1);
        chk.expect_sig(S_ROT_BUSY, 1);
        ddr_busy = 1'b0;
        hps_download = 1'b0;
        rot_we = 1'b0;
    endtask

    // Watchdog
    initial begin
        #(N_TESTS * 200 * 10);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk_sys = 1'b0;
        rst = 1'b1;
        hps_download = 1'b0;
        hps_wr = 1'b0;
        hps_index = '0;
        hps_addr = '0;
        hps_dout = '0;
        prog_rdy = 1'b0;
        status = '0;
        rotate = 1'b0;
        hs = 1'b0;
        vs = 1'b0;
        pxl_cen = 1'b0;
        ddrld_rd = 1'b0;
        ddrld_addr = '0;
        ddrld_burstcnt = '0;
        rot_rd = 1'b0;
        rot_we = 1'b0;
        rot_addr = '0;
        rot_burstcnt = '0;
        rot_be = '0;
        ddr_busy = 1'b0;
        rng = 32'h39f8;
        core_seen = '0;
        load_table();
        repeat (16) @(negedge clk_sys);
        rst = 1'b0;
        @(negedge clk_sys);
        for (int i = 0; i < N_TESTS; i++) begin
            case (kind[i])
                K_ROM:    rom_write(hps_addr_t'(op_a[i]));
                K_SET:    set_write(byte_t'(op_a[i]), hps_addr_t'(op_b[i]), byte_t'(op_c[i]));
                K_CHK: begin
                    chk.expect_sig(S_CHEAT, 64'(op_a[i][31:0]));
                    chk.expect_sig(S_DIPSW, 64'(op_b[i]));
                    chk.expect_sig(S_CORE, 64'(op_c[i][7:0]));
                    core_seen = op_c[i][7:0];
                end
                K_STATUS: status_check(op_a[i], op_b[i][0]);
                K_VIDEO:  resync_check(int'(op_a[i]), int'(op_b[i]));
                default:  ddr_check();
            endcase
            chk.finish_test(i, kind_name[kind[i]]);
        end
        chk.print_counts();
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hdl/mister_pkg.sv
hdl/hps_dwnld.sv
hdl/status_decode.sv
hdl/video_resync.sv
hdl/ddr_arbiter.sv
hdl/mister_shell.sv
bench/shell_checker.sv
bench/shell_props.sv
bench/tb_mister_shell.sv

/* run.sh */
#!/bin/sh
# Build and run the shell testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_mister_shell -o sim_shell > build.log 2>&1 \
    && ./obj_dir/sim_shell > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "TEST OK" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
